// ==== src.f ====
source/mont_pkg.sv
source/digit_adder.sv
source/mont_datapath.sv
source/mont_ctrl.sv
source/mont_regs.sv
source/mont_top.sv
dv/mont_props.sv
dv/mont_checker.sv
dv/tb_mont.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mont
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_mont.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mont;

    localparam int WIDTH   = 32;
    localparam int DIGIT   = 8;
    localparam int n_fixed = 6;
    localparam int n_rand  = 6;
    localparam int n_rows  = n_fixed + n_rand;
    localparam int n_tests = n_rows + 2;
    // worst case for one operation plus bus traffic
    localparam int op_cycles = WIDTH * 3 * ((WIDTH + 2 + DIGIT - 1) / DIGIT + 4) + 50;
    localparam int wd_cycles = n_tests * op_cycles;

    logic               clk;
    logic               rst;
    mont_pkg::apb_req_t apb_req;
    mont_pkg::apb_rsp_t apb_rsp;
    logic               expect_err;
    logic               test_end;
    logic [127:0]       test_name;
    int                 pass_cnt;
    int                 fail_cnt;
    integer             seed;

    // stimulus table
    logic [127:0] row_name [n_rows];
    logic [31:0]  row_a    [n_rows];
    logic [31:0]  row_b    [n_rows];
    logic [31:0]  row_m    [n_rows];
    logic         row_err  [n_rows];

    mont_top #(
        .WIDTH (WIDTH),
        .DIGIT (DIGIT)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    mont_checker #(
        .WIDTH (WIDTH)
    ) checker0 (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .expect_err (expect_err),
        .test_end   (test_end),
        .test_name  (test_name),
        .pass_cnt   (pass_cnt),
        .fail_cnt   (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic set_row(input int idx, input logic [127:0] name,
                           input logic [31:0] a, b, m, input logic err);
        row_name[idx] = name;
        row_a[idx]    = a;
        row_b[idx]    = b;
        row_m[idx]    = m;
        row_err[idx]  = err;
    endtask

    task automatic build_table();
        logic [31:0] ar;
        logic [31:0] br;
        logic [31:0] mr;
        int          k;
        set_row(0, "a_zero", 32'h0000_0000, 32'h0123_4567, 32'hF000_0001, 1'b0);
        set_row(1, "a_b_one", 32'h0000_0001, 32'h0000_0001, 32'h0000_0F0F, 1'b0);
        set_row(2, "m_max", 32'hDEAD_BEEF, 32'h1234_5678, 32'hFFFF_FFFF, 1'b0);
        set_row(3, "m_max_top", 32'hFFFF_FFFE, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 1'b0);
        set_row(4, "small_m", 32'h0000_0005, 32'h0000_0007, 32'h0000_000D, 1'b0);
        set_row(5, "busy_write", 32'h89AB_CDEF, 32'h0123_4567, 32'hC000_0001, 1'b1);
        for (k = 0; k < n_rand; k++) begin
            // odd modulus, operands reduced below it
            mr = $random(seed);
            mr = mr | 32'h8000_0001;
            ar = $random(seed);
            ar = ar % mr;
            br = $random(seed);
            br = br % mr;
            set_row(n_fixed + k, 128'({"random_", 8'h30 + 8'(k)}), ar, br, mr, 1'b0);
        end
    endtask

    // one APB transfer, called 1 ns after a rising edge
    task automatic apb_xfer(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic err,
                            output logic [31:0] rdata);
        expect_err      = err;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        expect_err      = 1'b0;
    endtask

    task automatic finish_test();
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    task automatic check_reset_values();
        logic [31:0] rd;
        test_name = "reset_values";
        apb_xfer(1'b0, mont_pkg::addr_status, '0, 1'b0, rd);
        apb_xfer(1'b0, mont_pkg::addr_a, '0, 1'b0, rd);
        apb_xfer(1'b0, mont_pkg::addr_b, '0, 1'b0, rd);
        apb_xfer(1'b0, mont_pkg::addr_m, '0, 1'b0, rd);
        apb_xfer(1'b0, mont_pkg::addr_result, '0, 1'b0, rd);
        apb_xfer(1'b0, mont_pkg::addr_ctrl, '0, 1'b0, rd);
        finish_test();
    endtask

    task automatic check_bad_access();
        logic [31:0] rd;
        test_name = "bad_access";
        apb_xfer(1'b0, 8'h18, '0, 1'b1, rd);
        apb_xfer(1'b1, 8'h40, 32'hFFFF_FFFF, 1'b1, rd);
        apb_xfer(1'b1, mont_pkg::addr_result, 32'h1234_5678, 1'b1, rd);
        apb_xfer(1'b1, mont_pkg::addr_status, 32'h0000_0003, 1'b1, rd);
        apb_xfer(1'b0, 8'hFC, '0, 1'b1, rd);
        apb_xfer(1'b0, mont_pkg::addr_result, '0, 1'b0, rd);
        finish_test();
    endtask

    task automatic run_op(input int idx);
        logic [31:0] rd;
        test_name = row_name[idx];
        apb_xfer(1'b1, mont_pkg::addr_a, row_a[idx], 1'b0, rd);
        apb_xfer(1'b1, mont_pkg::addr_b, row_b[idx], 1'b0, rd);
        apb_xfer(1'b1, mont_pkg::addr_m, row_m[idx], 1'b0, rd);
        apb_xfer(1'b1, mont_pkg::addr_ctrl, 32'h0000_0001, 1'b0, rd);
        if (row_err[idx]) begin
            // both must bounce while the engine runs
            apb_xfer(1'b1, mont_pkg::addr_a, ~row_a[idx], 1'b1, rd);
            apb_xfer(1'b1, mont_pkg::addr_ctrl, 32'h0000_0001, 1'b1, rd);
        end
        rd = '0;
        while (!rd[mont_pkg::status_done_bit]) begin
            apb_xfer(1'b0, mont_pkg::addr_status, '0, 1'b0, rd);
        end
        // done is sticky
        repeat (2) apb_xfer(1'b0, mont_pkg::addr_status, '0, 1'b0, rd);
        apb_xfer(1'b0, mont_pkg::addr_result, '0, 1'b0, rd);
        if (row_err[idx]) begin
            apb_xfer(1'b0, mont_pkg::addr_a, '0, 1'b0, rd);
        end
        finish_test();
    endtask

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("error: simulation timed out after %0d cycles", wd_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int i;
        apb_req    = '0;
        expect_err = 1'b0;
        test_end   = 1'b0;
        test_name  = '0;
        rst        = 1'b1;
        seed       = 32'hf9fd96f2;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_values();
        check_bad_access();
        for (i = 0; i < n_rows; i++) begin
            run_op(i);
        end
        @(posedge clk);
        $display("%0d of %0d tests passed, %0d failed", pass_cnt, n_tests, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == n_tests) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mont_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_checker #(
    parameter int WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mont_pkg::apb_req_t   apb_req,
    input  wire mont_pkg::apb_rsp_t   apb_rsp,
    input  wire                       expect_err,
    input  wire                       test_end,
    input  wire [127:0]               test_name,
    output int                        pass_cnt,
    output int                        fail_cnt
);

    localparam int dw = mont_pkg::apb_data_w;

    // register model
    logic [dw-1:0] a_r;
    logic [dw-1:0] b_r;
    logic [dw-1:0] m_r;
    logic [dw-1:0] exp_res;
    logic          started;
    logic          first_rd;
    logic          done_seen;
    int            test_errs;

    // bit loop, then subtract M while C >= M
    function automatic logic [dw-1:0] mont_model(input logic [dw-1:0] a, b, m);
        logic [63:0] c;
        int          i;
        c = 64'h0;
        for (i = 0; i < WIDTH; i++) begin
            if (a[i]) begin
                c = c + {32'h0, b};
            end
            if (c[0]) begin
                c = c + {32'h0, m};
            end
            c = c >> 1;
        end
        while (m != '0 && c >= {32'h0, m}) begin
            c = c - {32'h0, m};
        end
        return c[dw-1:0];
    endfunction

    task automatic report(input string what, input logic [dw-1:0] exp, input logic [dw-1:0] act);
        $display("FAIL %0s: %0s expected %h actual %h", test_name, what, exp, act);
        test_errs++;
    endtask

    task automatic check_access();
        logic [7:0]    addr;
        logic [dw-1:0] act;
        logic [dw-1:0] exp;
        logic [dw-1:0] busy_word;
        logic [dw-1:0] done_word;
        logic          cmp;
        addr      = apb_req.paddr;
        act       = apb_rsp.prdata;
        exp       = '0;
        cmp       = 1'b1;
        busy_word = '0;
        done_word = '0;
        busy_word[mont_pkg::status_busy_bit] = 1'b1;
        done_word[mont_pkg::status_done_bit] = 1'b1;
        if (apb_rsp.pready != 1'b1) begin
            report($sformatf("pready at %h", addr), dw'(1'b1), dw'(apb_rsp.pready));
        end
        if (apb_rsp.pslverr != expect_err) begin
            report($sformatf("pslverr at %h", addr), dw'(expect_err), dw'(apb_rsp.pslverr));
        end
        if (apb_req.pwrite) begin
            if (!expect_err) begin
                case (addr)
                    mont_pkg::addr_a: a_r = apb_req.pwdata;
                    mont_pkg::addr_b: b_r = apb_req.pwdata;
                    mont_pkg::addr_m: m_r = apb_req.pwdata;
                    mont_pkg::addr_ctrl: begin
                        if (apb_req.pwdata[mont_pkg::ctrl_start_bit]) begin
                            exp_res   = mont_model(a_r, b_r, m_r);
                            started   = 1'b1;
                            first_rd  = 1'b1;
                            done_seen = 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end else if (!expect_err) begin
            case (addr)
                mont_pkg::addr_a: exp = a_r;
                mont_pkg::addr_b: exp = b_r;
                mont_pkg::addr_m: exp = m_r;
                mont_pkg::addr_result: begin
                    exp = exp_res;
                    cmp = !started || done_seen;
                end
                mont_pkg::addr_status: begin
                    if (!started) begin
                        exp = '0;
                    end else if (first_rd) begin
                        exp = busy_word;
                    end else if (done_seen) begin
                        exp = done_word;
                    end else begin
                        // still running or just finished
                        cmp = 1'b0;
                        if (act == done_word) begin
                            done_seen = 1'b1;
                        end else if (act != busy_word) begin
                            $display("FAIL %0s: status expected %h or %h actual %h",
                                     test_name, busy_word, done_word, act);
                            test_errs++;
                        end
                    end
                    first_rd = 1'b0;
                end
                default: exp = '0;
            endcase
            if (cmp && act != exp) begin
                report($sformatf("read %h", addr), exp, act);
            end
        end else if (act != '0) begin
            report($sformatf("read %h", addr), '0, act);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            a_r       = '0;
            b_r       = '0;
            m_r       = '0;
            exp_res   = '0;
            started   = 1'b0;
            first_rd  = 1'b0;
            done_seen = 1'b0;
            test_errs = 0;
            pass_cnt  = 0;
            fail_cnt  = 0;
        end else begin
            if (apb_req.psel && apb_req.penable) begin
                check_access();
            end
            if (test_end) begin
                if (test_errs == 0) begin
                    $display("PASS %0s", test_name);
                    pass_cnt++;
                end else begin
                    $display("FAIL %0s: %0d checks failed", test_name, test_errs);
                    fail_cnt++;
                end
                test_errs = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/mont_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_props (
    input wire                            clk,
    input wire                            rst,
    input wire mont_pkg::apb_req_t        apb_req,
    input wire mont_pkg::apb_rsp_t        apb_rsp,
    input wire                            busy,
    input wire                            start,
    input wire [mont_pkg::apb_data_w-1:0] status_w
);

    penable_with_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel)
        else $error("penable high without psel");

    pready_high: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready)
        else $error("pready is low");

    // status word never shows busy and done together
    busy_done_excl: assert property (@(posedge clk) disable iff (rst)
        !(status_w[mont_pkg::status_busy_bit] && status_w[mont_pkg::status_done_bit]))
        else $error("busy and done both set in status");

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("start pulse while busy");

endmodule

bind mont_regs mont_props props0 (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .busy     (busy),
    .start    (start),
    .status_w (status_w)
);

`default_nettype wire

// ==== source/mont_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_top #(
    parameter int WIDTH = 32,
    parameter int DIGIT = 8
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mont_pkg::apb_req_t   apb_req,
    output mont_pkg::apb_rsp_t        apb_rsp
);

    logic               start;
    logic               busy;
    logic               finish;
    logic [WIDTH-1:0]   a;
    logic [WIDTH-1:0]   b;
    logic [WIDTH-1:0]   m;
    logic [WIDTH-1:0]   result;
    mont_pkg::dp_ctrl_t ctl;
    mont_pkg::dp_stat_t stat;

    mont_regs #(
        .WIDTH (WIDTH)
    ) regs0 (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .busy    (busy),
        .finish  (finish),
        .result  (result),
        .apb_rsp (apb_rsp),
        .start   (start),
        .a       (a),
        .b       (b),
        .m       (m)
    );

    mont_ctrl #(
        .WIDTH (WIDTH)
    ) ctrl0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .stat   (stat),
        .ctl    (ctl),
        .busy   (busy),
        .finish (finish)
    );

    mont_datapath #(
        .WIDTH (WIDTH),
        .DIGIT (DIGIT)
    ) dp0 (
        .clk    (clk),
        .rst    (rst),
        .ctl    (ctl),
        .a      (a),
        .b      (b),
        .m      (m),
        .stat   (stat),
        .result (result)
    );

endmodule

`default_nettype wire

// ==== source/mont_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_regs #(
    parameter int WIDTH = 32
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire mont_pkg::apb_req_t    apb_req,
    input  wire                        busy,
    input  wire                        finish,
    input  wire [WIDTH-1:0]            result,
    output mont_pkg::apb_rsp_t         apb_rsp,
    output logic                       start,
    output logic [WIDTH-1:0]           a,
    output logic [WIDTH-1:0]           b,
    output logic [WIDTH-1:0]           m
);

    localparam int dw = mont_pkg::apb_data_w;

    logic          access;
    logic          wr_acc;
    logic          addr_ok;
    logic          wr_bad;
    logic          wr_ok;
    logic          done_flag;
    logic [dw-1:0] status_w;
    logic [dw-1:0] rdata;

    assign access = apb_req.psel && apb_req.penable;
    assign wr_acc = access && apb_req.pwrite;

    always_comb begin
        status_w = '0;
        status_w[mont_pkg::status_busy_bit] = busy;
        status_w[mont_pkg::status_done_bit] = done_flag;
    end

    // address decode, read mux and write legality
    always_comb begin
        addr_ok = 1'b1;
        wr_bad  = 1'b0;
        rdata   = '0;
        case (apb_req.paddr)
            mont_pkg::addr_ctrl: begin
                wr_bad = busy && apb_req.pwdata[mont_pkg::ctrl_start_bit];
            end
            mont_pkg::addr_status: begin
                rdata  = status_w;
                wr_bad = 1'b1;
            end
            mont_pkg::addr_a: begin
                rdata  = dw'(a);
                wr_bad = busy;
            end
            mont_pkg::addr_b: begin
                rdata  = dw'(b);
                wr_bad = busy;
            end
            mont_pkg::addr_m: begin
                rdata  = dw'(m);
                wr_bad = busy;
            end
            mont_pkg::addr_result: begin
                rdata  = dw'(result);
                wr_bad = 1'b1;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    assign wr_ok = wr_acc && addr_ok && !wr_bad;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!addr_ok || (apb_req.pwrite && wr_bad));

    always_ff @(posedge clk) begin
        if (rst) begin
            a         <= '0;
            b         <= '0;
            m         <= '0;
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            start <= 1'b0;
            if (finish) begin
                done_flag <= 1'b1;
            end
            if (wr_ok) begin
                case (apb_req.paddr)
                    mont_pkg::addr_ctrl: begin
                        if (apb_req.pwdata[mont_pkg::ctrl_start_bit]) begin
                            start     <= 1'b1;
                            done_flag <= 1'b0;
                        end
                    end
                    mont_pkg::addr_a: a <= apb_req.pwdata[WIDTH-1:0];
                    mont_pkg::addr_b: b <= apb_req.pwdata[WIDTH-1:0];
                    mont_pkg::addr_m: m <= apb_req.pwdata[WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mont_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_ctrl #(
    parameter int WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire mont_pkg::dp_stat_t   stat,
    output mont_pkg::dp_ctrl_t        ctl,
    output logic                      busy,
    output logic                      finish
);

    localparam int cnt_w = $clog2(WIDTH + 1);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_bit     = 3'd1;
    localparam logic [2:0] st_add_b   = 3'd2;
    localparam logic [2:0] st_par     = 3'd3;
    localparam logic [2:0] st_add_m   = 3'd4;
    localparam logic [2:0] st_shift   = 3'd5;
    localparam logic [2:0] st_sub     = 3'd6;
    localparam logic [2:0] st_sub_chk = 3'd7;

    logic [2:0]       state;
    logic [2:0]       state_nxt;
    logic [cnt_w-1:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            bit_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_idle && start) begin
                bit_cnt <= cnt_w'(WIDTH);
            end else if (state == st_shift) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        ctl       = '0;
        finish    = 1'b0;
        case (state)
            st_idle: begin
                if (start) begin
                    ctl.load_a    = 1'b1;
                    ctl.acc_clear = 1'b1;
                    state_nxt     = st_bit;
                end
            end
            st_bit: begin
                if (bit_cnt == '0) begin
                    // loop done, C may already be reduced
                    ctl.capture_result = 1'b1;
                    state_nxt          = st_sub;
                end else if (stat.a_lsb) begin
                    ctl.add_start = 1'b1;
                    state_nxt     = st_add_b;
                end else begin
                    state_nxt = st_par;
                end
            end
            st_add_b: begin
                if (stat.add_done) begin
                    ctl.acc_load_sum = 1'b1;
                    state_nxt        = st_par;
                end
            end
            st_par: begin
                if (stat.acc_lsb) begin
                    ctl.sel_m     = 1'b1;
                    ctl.add_start = 1'b1;
                    state_nxt     = st_add_m;
                end else begin
                    state_nxt = st_shift;
                end
            end
            st_add_m: begin
                ctl.sel_m = 1'b1;
                if (stat.add_done) begin
                    ctl.acc_load_sum = 1'b1;
                    state_nxt        = st_shift;
                end
            end
            st_shift: begin
                ctl.acc_shift = 1'b1;
                ctl.shift_a   = 1'b1;
                state_nxt     = st_bit;
            end
            st_sub: begin
                ctl.sel_m     = 1'b1;
                ctl.add_sub   = 1'b1;
                ctl.add_start = 1'b1;
                state_nxt     = st_sub_chk;
            end
            st_sub_chk: begin
                ctl.sel_m   = 1'b1;
                ctl.add_sub = 1'b1;
                if (stat.add_done) begin
                    if (stat.add_borrow) begin
                        finish    = 1'b1;
                        state_nxt = st_idle;
                    end else begin
                        ctl.acc_load_sum   = 1'b1;
                        ctl.capture_result = 1'b1;
                        state_nxt          = st_sub;
                    end
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    assign busy = (state != st_idle);

endmodule

`default_nettype wire

// ==== source/mont_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_datapath #(
    parameter int WIDTH = 32,
    parameter int DIGIT = 8
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mont_pkg::dp_ctrl_t   ctl,
    input  wire [WIDTH-1:0]           a,
    input  wire [WIDTH-1:0]           b,
    input  wire [WIDTH-1:0]           m,
    output mont_pkg::dp_stat_t        stat,
    output logic [WIDTH-1:0]          result
);

    localparam int cw = WIDTH + 2;

    logic [WIDTH-1:0]    a_sh;
    logic [cw-1:0]       acc;
    logic [cw-1:0]       acc_nxt;
    logic [cw-1:0]       add_y;
    mont_pkg::add_word_u add_sum;
    logic                add_done;

    // operand A, consumed lsb first
    always_ff @(posedge clk) begin
        if (ctl.load_a) begin
            a_sh <= a;
        end else if (ctl.shift_a) begin
            a_sh <= a_sh >> 1;
        end
    end

    assign add_y = ctl.sel_m ? {2'b00, m} : {2'b00, b};

    digit_adder #(
        .WIDTH (WIDTH),
        .DIGIT (DIGIT)
    ) adder0 (
        .clk      (clk),
        .rst      (rst),
        .start    (ctl.add_start),
        .subtract (ctl.add_sub),
        .x        (acc),
        .y        (add_y),
        .sum      (add_sum),
        .done     (add_done)
    );

    // accumulator C next value
    always_comb begin
        acc_nxt = acc;
        if (ctl.acc_clear) begin
            acc_nxt = '0;
        end else if (ctl.acc_load_sum) begin
            acc_nxt = ctl.add_sub ? add_sum.sub.diff[cw-1:0] : add_sum.sum[cw-1:0];
        end else if (ctl.acc_shift) begin
            acc_nxt = acc >> 1;
        end
    end

    always_ff @(posedge clk) begin
        acc <= acc_nxt;
    end

    // result picks up C as it is being written
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (ctl.capture_result) begin
            result <= acc_nxt[WIDTH-1:0];
        end
    end

    assign stat.a_lsb      = a_sh[0];
    assign stat.acc_lsb    = acc[0];
    assign stat.add_done   = add_done;
    assign stat.add_borrow = add_sum.sub.borrow;

endmodule

`default_nettype wire

// ==== source/digit_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_adder #(
    parameter int WIDTH = 32,
    parameter int DIGIT = 8
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire                  subtract,
    input  wire [WIDTH+1:0]      x,
    input  wire [WIDTH+1:0]      y,
    output mont_pkg::add_word_u  sum,
    output logic                 done
);

    localparam int ow     = WIDTH + 2;
    localparam int nd     = (ow + DIGIT - 1) / DIGIT;
    localparam int pw     = nd * DIGIT;
    localparam int cnt_w  = $clog2(nd + 1);
    localparam int sw     = mont_pkg::add_max_w;
    localparam int diff_w = mont_pkg::add_max_w - 1;

    logic [ow-1:0]    y_op;
    logic [pw-1:0]    x_ext;
    logic [pw-1:0]    y_ext;
    logic [pw-1:0]    x_sh;
    logic [pw-1:0]    y_sh;
    logic [pw-1:0]    acc;
    logic [DIGIT-1:0] dig_x;
    logic [DIGIT-1:0] dig_y;
    logic             dig_c;
    logic [DIGIT:0]   dig_sum;
    logic             cy;
    logic             sub_q;
    logic [cnt_w-1:0] left;
    logic [pw:0]      full;
    logic             top;

    // subtract is x + ~y + 1 over the operand width
    assign y_op  = subtract ? ~y : y;
    assign x_ext = pw'(x);
    assign y_ext = pw'(y_op);

    // first digit goes in on the start cycle itself
    assign dig_x   = start ? x_ext[DIGIT-1:0] : x_sh[DIGIT-1:0];
    assign dig_y   = start ? y_ext[DIGIT-1:0] : y_sh[DIGIT-1:0];
    assign dig_c   = start ? subtract : cy;
    assign dig_sum = {1'b0, dig_x} + {1'b0, dig_y} + {{DIGIT{1'b0}}, dig_c};

    always_ff @(posedge clk) begin
        if (rst) begin
            left  <= '0;
            done  <= 1'b0;
            sub_q <= 1'b0;
            cy    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                left  <= cnt_w'(nd - 1);
                done  <= (nd == 1);
                sub_q <= subtract;
            end else if (left != '0) begin
                left <= left - 1'b1;
                done <= (left == 1);
            end
            if (start || left != '0) begin
                cy <= dig_sum[DIGIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || left != '0) begin
            x_sh <= (start ? x_ext : x_sh) >> DIGIT;
            y_sh <= (start ? y_ext : y_sh) >> DIGIT;
            acc  <= (acc >> DIGIT) | (pw'(dig_sum[DIGIT-1:0]) << (pw - DIGIT));
        end
    end

    assign full = {cy, acc};
    assign top  = full[ow];

    // difference is sign extended so the borrow lands in the union's top bit
    always_comb begin
        if (sub_q) begin
            sum.sub.borrow = ~top;
            sum.sub.diff   = diff_w'($signed({~top, full[ow-1:0]}));
        end else begin
            sum.sum = sw'(full[ow:0]);
        end
    end

endmodule

`default_nettype wire

// ==== source/mont_pkg.sv ====
`default_nettype none

package mont_pkg;

    localparam int apb_data_w = 32;
    localparam int apb_addr_w = 8;

    // register map
    localparam logic [apb_addr_w-1:0] addr_ctrl   = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_status = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_a      = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_b      = 8'h0C;
    localparam logic [apb_addr_w-1:0] addr_m      = 8'h10;
    localparam logic [apb_addr_w-1:0] addr_result = 8'h14;

    localparam int ctrl_start_bit  = 0;
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

    // widest adder word, for WIDTH = 32
    localparam int add_max_w = 35;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_data_w-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic load_a;
        logic shift_a;
        logic acc_clear;
        logic acc_load_sum;
        logic acc_shift;
        logic sel_m;
        logic add_start;
        logic add_sub;
        logic capture_result;
    } dp_ctrl_t;

    typedef struct packed {
        logic a_lsb;
        logic acc_lsb;
        logic add_done;
        logic add_borrow;
    } dp_stat_t;

    // carry sits on top after an add, borrow after a subtract
    typedef union packed {
        logic [add_max_w-1:0] sum;
        struct packed {
            logic                 borrow;
            logic [add_max_w-2:0] diff;
        } sub;
    } add_word_u;

endpackage

`default_nettype wire
